// File: verification/fb_stim.txt
# R frame            draw request at the start of that frame
# P frame x y value  expected r, g and b (hex) at screen point (x, y), raster order
P 0 0 0 00
P 0 159 0 00
P 0 160 0 00
P 0 80 60 00
P 0 0 119 00
P 0 159 119 00
R 1
P 1 80 60 00
P 2 0 0 FF
P 2 80 0 FF
P 2 159 0 FF
P 2 160 0 00
P 2 1 1 00
P 2 0 60 FF
P 2 80 60 00
P 2 159 60 FF
P 2 0 119 FF
P 2 80 119 FF
P 2 159 119 FF
P 2 0 120 00
P 2 400 300 00
R 3
P 4 0 0 FF
P 4 1 1 00
P 4 80 60 00
P 4 159 119 FF

// File: fb_mono_draw_top.f
+incdir+include
hw/fb_pkg.sv
hw/display_if.sv
hw/display_480p.sv
hw/bram_sdp.sv
hw/fb_box_drawer.sv
hw/fb_scanout.sv
hw/fb_mono_draw_top.sv
verification/fb_mono_draw_tb.sv

// File: Bender.yml
package:
  name: fb_mono_draw

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/fb_pkg.sv
      - hw/display_if.sv
      - hw/display_480p.sv
      - hw/bram_sdp.sv
      - hw/fb_box_drawer.sv
      - hw/fb_scanout.sv
      - hw/fb_mono_draw_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/fb_mono_draw_tb.sv

// File: verification/fb_mono_draw_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the mono framebuffer top level. Replays draw requests and
// pixel probes from the stim file and checks the SDL colour outputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fb_defs.svh"

module fb_mono_draw_tb;

    localparam int     CLK_PERIOD   = 8;
    localparam longint FRAME_CYCLES = 420000;  // 800 x 525
    localparam int     FRAME_SX     = -(`H_FP + `H_SYNC + `H_BP);  // first blanking pixel
    localparam int     FRAME_SY     = -(`V_FP + `V_SYNC + `V_BP);

    logic                     clk_pix;
    logic                     rst_pix;
    logic                     draw_req;
    logic                     draw_busy;
    logic signed [`CORDW-1:0] sdl_sx;
    logic signed [`CORDW-1:0] sdl_sy;
    logic                     sdl_de;
    logic                     sdl_frame;
    logic [7:0]               sdl_r;
    logic [7:0]               sdl_g;
    logic [7:0]               sdl_b;

    // stim entries, one per file line
    byte kind_q[$];
    int  frame_q[$];
    int  x_q[$];
    int  y_q[$];
    int  val_q[$];

    int   last_frame;
    int   frame_num;          // -1 until first frame after reset
    int   busy_check_frame;   // frame whose first pixel must see busy low
    int   tests_run;
    int   tests_failed;
    bit   stim_ok;
    logic loaded;

    fb_mono_draw_top fb_mono_draw_top_inst (
        .clk_pix,
        .rst_pix,
        .draw_req,
        .draw_busy,
        .sdl_sx,
        .sdl_sy,
        .sdl_de,
        .sdl_frame,
        .sdl_r,
        .sdl_g,
        .sdl_b
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    always @(posedge clk_pix) begin
        if (rst_pix) begin
            frame_num <= -1;
        end else if (sdl_frame) begin
            frame_num <= frame_num + 1;
        end
    end

    // frame pulse belongs to the first blanking position, de low there
    always @(posedge clk_pix) begin
        if (!rst_pix && sdl_frame === 1'b1) begin
            tests_run++;
            if (sdl_de !== 1'b0 || sdl_sx != FRAME_SX || sdl_sy != FRAME_SY) begin
                tests_failed++;
                $display("error at %0t: frame pulse at (%0d,%0d) with de %b",
                         $time, sdl_sx, sdl_sy, sdl_de);
            end else begin
                $display("test %0d: frame pulse at (%0d,%0d), de low, pass",
                         tests_run, sdl_sx, sdl_sy);
            end
        end
    end

    // busy must have dropped by the first active pixel of the drawing frame
    always @(posedge clk_pix) begin
        if (busy_check_frame >= 0 && frame_num == busy_check_frame &&
            sdl_sx == 0 && sdl_sy == 0) begin
            tests_run++;
            if (draw_busy !== 1'b0) begin
                tests_failed++;
                $display("error at %0t: draw_busy still high at (0,0) of frame %0d",
                         $time, frame_num);
            end else begin
                $display("test %0d: busy low at start of frame %0d, pass",
                         tests_run, frame_num);
            end
            busy_check_frame = -1;
        end
    end

    task automatic load_stim(output bit ok);
        int  fd;
        int  n;
        int  bad;
        byte kind;
        int  fr;
        int  px;
        int  py;
        int  val;
        logic [8*128-1:0] skip_line;
        ok         = 1'b0;
        bad        = 0;
        last_frame = 0;
        fd = $fopen("verification/fb_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verification/fb_stim.txt");
        end else begin
            n = $fscanf(fd, " %c", kind);
            while (n == 1) begin
                if (kind == "#") begin
                    n = $fgets(skip_line, fd);  // comment line
                end else if (kind == "R" || kind == "P") begin
                    px  = 0;
                    py  = 0;
                    val = 0;
                    if (kind == "R") begin
                        n = $fscanf(fd, "%d", fr);
                        if (n != 1) bad++;
                    end else begin
                        n = $fscanf(fd, "%d %d %d %h", fr, px, py, val);
                        if (n != 4) bad++;
                    end
                    kind_q.push_back(kind);
                    frame_q.push_back(fr);
                    x_q.push_back(px);
                    y_q.push_back(py);
                    val_q.push_back(val);
                    if (fr > last_frame) last_frame = fr;
                end else begin
                    $display("unknown command in stimulus file, line skipped");
                    bad++;
                    n = $fgets(skip_line, fd);
                end
                n = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
            ok = (bad == 0 && kind_q.size() > 0);
        end
    endtask

    task automatic send_request(input int fr);
        @(posedge clk_pix);
        while (frame_num < fr) @(posedge clk_pix);
        tests_run++;
        if (frame_num > fr) begin
            tests_failed++;
            $display("test %0d: request for frame %0d came too late, stim out of order",
                     tests_run, fr);
        end else begin
            draw_req <= 1'b1;
            @(posedge clk_pix);
            draw_req <= 1'b0;
            @(posedge clk_pix);       // drawer has seen the request by now
            if (draw_busy !== 1'b1) begin
                tests_failed++;
                $display("error at %0t: draw_busy low after request in frame %0d",
                         $time, fr);
            end else begin
                $display("test %0d: request in frame %0d, busy high, pass", tests_run, fr);
            end
            busy_check_frame = fr + 1;
        end
    endtask

    task automatic check_probe(input int idx);
        int         fr;
        int         px;
        int         py;
        logic [7:0] expected;
        logic       exp_de;
        fr       = frame_q[idx];
        px       = x_q[idx];
        py       = y_q[idx];
        expected = val_q[idx][7:0];
        exp_de   = (px >= 0 && px < `H_RES && py >= 0 && py < `V_RES);  // active area
        @(posedge clk_pix);
        while (frame_num < fr || (frame_num == fr && !(sdl_sx == px && sdl_sy == py))) begin
            @(posedge clk_pix);
        end
        tests_run++;
        if (frame_num != fr) begin
            tests_failed++;
            $display("test %0d: probe (%0d,%0d) of frame %0d was missed, stim out of order",
                     tests_run, px, py, fr);
        end else if (sdl_r !== expected || sdl_g !== expected || sdl_b !== expected ||
                     sdl_de !== exp_de) begin
            tests_failed++;
            $display("error at %0t: frame %0d (%0d,%0d) rgb %h %h %h de %b, expected %h de %b",
                     $time, fr, px, py, sdl_r, sdl_g, sdl_b, sdl_de, expected, exp_de);
        end else begin
            $display("test %0d: frame %0d (%0d,%0d) = %h, pass", tests_run, fr, px, py,
                     expected);
        end
    endtask

    initial begin
        clk_pix          = 1'b0;
        rst_pix          = 1'b1;
        draw_req         = 1'b0;
        frame_num        = -1;
        busy_check_frame = -1;
        tests_run        = 0;
        tests_failed     = 0;
        loaded           = 1'b0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("stimulus file missing, empty or malformed, nothing was run");
            $display("TEST FAILED");
        end else begin
            loaded = 1'b1;
            repeat (10) @(posedge clk_pix);
            rst_pix <= 1'b0;
            for (int i = 0; i < kind_q.size(); i++) begin
                if (kind_q[i] == "R") begin
                    send_request(frame_q[i]);
                end else begin
                    check_probe(i);
                end
            end
            wait (busy_check_frame < 0);
            $display("%0d tests, %0d passed, %0d failed", tests_run,
                     tests_run - tests_failed, tests_failed);
            if (tests_failed == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

    // watchdog, two spare frames past the last one in the stim file
    initial begin
        longint limit;
        wait (loaded === 1'b1);
        limit = (longint'(last_frame) + 2) * FRAME_CYCLES * CLK_PERIOD;
        #(limit);
        $display("timeout: run still going after %0d time units", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: hw/fb_mono_draw_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mono framebuffer drawing top level for SDL simulation. Connects timing,
// border drawer, framebuffer and scanout; all SDL outputs are registered.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fb_defs.svh"

module fb_mono_draw_top (
    input  wire logic                clk_pix,
    input  wire logic                rst_pix,
    input  wire logic                draw_req,   // redraw border at next frame
    output logic                     draw_busy,
    output logic signed [`CORDW-1:0] sdl_sx,
    output logic signed [`CORDW-1:0] sdl_sy,
    output logic                     sdl_de,
    output logic                     sdl_frame,
    output logic [7:0]               sdl_r,
    output logic [7:0]               sdl_g,
    output logic [7:0]               sdl_b
);

    display_if disp ();

    display_480p display_inst (
        .clk_pix,
        .rst_pix,
        .disp (disp.src)
    );

    // framebuffer write and read ports
    logic              fb_we;
    fb_pkg::fb_addr_t  fb_addr_write;
    fb_pkg::fb_addr_t  fb_addr_read;
    fb_pkg::fb_colr_t  fb_colr_write;
    fb_pkg::fb_colr_t  fb_colr_read;

    bram_sdp #(
        .WIDTH (1),
        .DEPTH (`FB_PIXELS)
    ) bram_inst (
        .clk        (clk_pix),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .addr_read  (fb_addr_read),
        .data_in    (fb_colr_write),
        .data_out   (fb_colr_read)
    );

    fb_box_drawer drawer_inst (
        .clk_pix,
        .rst_pix,
        .disp          (disp.snk),
        .draw_req,
        .busy          (draw_busy),
        .fb_we,
        .fb_addr_write,
        .fb_colr_write
    );

    fb_pkg::chan_t paint_r;
    fb_pkg::chan_t paint_g;
    fb_pkg::chan_t paint_b;

    fb_scanout scanout_inst (
        .clk_pix,
        .rst_pix,
        .disp         (disp.snk),
        .fb_addr_read,
        .fb_colr_read,
        .paint_r,
        .paint_g,
        .paint_b
    );

    // SDL output stage, colour stays aligned with position
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sdl_de    <= 1'b0;
            sdl_frame <= 1'b0;
        end else begin
            sdl_de    <= disp.de;
            sdl_frame <= disp.frame;
        end
    end

    always_ff @(posedge clk_pix) begin
        sdl_sx <= disp.sx;
        sdl_sy <= disp.sy;
        sdl_r  <= paint_r;
        sdl_g  <= paint_g;
        sdl_b  <= paint_b;
    end

endmodule

// File: hw/fb_scanout.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads the framebuffer in raster order and paints it into the top-left
// corner of the screen; reads start one cycle early to cover BRAM latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fb_defs.svh"

module fb_scanout (
    input  wire logic         clk_pix,
    input  wire logic         rst_pix,
    display_if.snk            disp,
    output fb_pkg::fb_addr_t  fb_addr_read,
    input  fb_pkg::fb_colr_t  fb_colr_read,
    output fb_pkg::chan_t     paint_r,
    output fb_pkg::chan_t     paint_g,
    output fb_pkg::chan_t     paint_b
);

    // read window is shifted one pixel left of the paint area
    localparam fb_pkg::coord_t RD_X_STA = -1;
    localparam fb_pkg::coord_t RD_X_END = `FB_WIDTH - 1;   // exclusive
    localparam fb_pkg::coord_t RD_Y_END = `FB_HEIGHT;      // exclusive

    logic read_fb;   // address valid this cycle
    logic paint;     // data valid this cycle
    logic pixel_on;

    always_comb begin
        read_fb = (disp.sy >= 0 && disp.sy < RD_Y_END &&
                   disp.sx >= RD_X_STA && disp.sx < RD_X_END);
    end

    // sequential read address, one word per painted pixel
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            fb_addr_read <= '0;
        end else if (disp.frame) begin
            fb_addr_read <= '0;
        end else if (read_fb) begin
            fb_addr_read <= fb_addr_read + fb_pkg::fb_addr_t'(1);
        end
    end

    // one cycle for the memory read
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            paint <= 1'b0;
        end else begin
            paint <= read_fb;
        end
    end

    assign pixel_on = paint && fb_colr_read[0];

    // expand the pixel bit to full channels, white on black
    always_comb begin
        paint_r = pixel_on ? 8'hFF : 8'h00;
        paint_g = pixel_on ? 8'hFF : 8'h00;
        paint_b = pixel_on ? 8'hFF : 8'h00;
    end

endmodule

// File: hw/fb_box_drawer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Draws a one-pixel border round the framebuffer edge. A draw_req arms the
// engine and the border is written at the next frame start, one pixel a cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fb_defs.svh"

module fb_box_drawer (
    input  wire logic         clk_pix,
    input  wire logic         rst_pix,
    display_if.snk            disp,
    input  wire logic         draw_req,
    output logic              busy,
    output logic              fb_we,
    output fb_pkg::fb_addr_t  fb_addr_write,
    output fb_pkg::fb_colr_t  fb_colr_write
);

    localparam int CNTW = $clog2(`FB_WIDTH);  // wide enough for the longer edge

    localparam logic [CNTW-1:0] ROW_LAST = CNTW'(`FB_WIDTH - 1);
    localparam logic [CNTW-1:0] COL_LAST = CNTW'(`FB_HEIGHT - 1);
    localparam fb_pkg::fb_addr_t ROW_STEP = fb_pkg::fb_addr_t'(`FB_WIDTH);

    fb_pkg::draw_state_e state;
    logic [CNTW-1:0] cnt_draw;  // pixels done on current edge

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            state <= fb_pkg::IDLE;
            fb_we <= 1'b0;
        end else begin
            case (state)
                fb_pkg::IDLE:
                    if (draw_req) state <= fb_pkg::ARMED;
                fb_pkg::ARMED:
                    if (disp.frame) begin  // start drawing in vertical blanking
                        fb_we         <= 1'b1;
                        fb_addr_write <= '0;
                        cnt_draw      <= '0;
                        state         <= fb_pkg::TOP;
                    end
                fb_pkg::TOP:
                    if (cnt_draw < ROW_LAST) begin
                        fb_addr_write <= fb_addr_write + fb_pkg::fb_addr_t'(1);
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        cnt_draw <= '0;  // right edge starts at top-right corner
                        state    <= fb_pkg::RIGHT;
                    end
                fb_pkg::RIGHT:
                    if (cnt_draw < COL_LAST) begin
                        fb_addr_write <= fb_addr_write + ROW_STEP;
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        fb_addr_write <= '0;
                        cnt_draw      <= '0;
                        state         <= fb_pkg::LEFT;
                    end
                fb_pkg::LEFT:
                    if (cnt_draw < COL_LAST) begin
                        fb_addr_write <= fb_addr_write + ROW_STEP;
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        cnt_draw <= '0;  // bottom edge from bottom-left corner
                        state    <= fb_pkg::BOTTOM;
                    end
                fb_pkg::BOTTOM:
                    if (cnt_draw < ROW_LAST) begin
                        fb_addr_write <= fb_addr_write + fb_pkg::fb_addr_t'(1);
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        fb_we <= 1'b0;
                        state <= fb_pkg::IDLE;
                    end
                default: begin
                    fb_we <= 1'b0;
                    state <= fb_pkg::IDLE;
                end
            endcase
        end
    end

    // requests are only taken in IDLE
    assign busy = (state != fb_pkg::IDLE);

    assign fb_colr_write = fb_pkg::fb_colr_t'(1);  // border is always lit

endmodule

// File: hw/bram_sdp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple dual-port block RAM, one write and one registered read port.
// Contents start at zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bram_sdp #(
    parameter int WIDTH = 8,     // data bits per word
    parameter int DEPTH = 256    // number of words
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] addr_write,
    input  wire logic [$clog2(DEPTH)-1:0] addr_read,
    input  wire logic [WIDTH-1:0]         data_in,
    output      logic [WIDTH-1:0]         data_out
);

    logic [WIDTH-1:0] memory [DEPTH];

    // blank contents for simulation
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            memory[addr_write] <= data_in;
        end
    end

    // read data appears one cycle after the address
    always_ff @(posedge clk) begin
        data_out <= memory[addr_read];
    end

endmodule

// File: hw/display_480p.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 display timing. Coordinates start in blanking so the active
// area is at sx, sy >= 0; drives the display interface source side.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fb_defs.svh"

module display_480p (
    input  wire logic clk_pix,
    input  wire logic rst_pix,
    display_if.src    disp
);

    // horizontal positions
    localparam fb_pkg::coord_t H_STA  = 0 - `H_FP - `H_SYNC - `H_BP;  // -160
    localparam fb_pkg::coord_t HS_STA = H_STA + `H_FP;
    localparam fb_pkg::coord_t HS_END = HS_STA + `H_SYNC;
    localparam fb_pkg::coord_t HA_END = `H_RES - 1;

    // vertical positions
    localparam fb_pkg::coord_t V_STA  = 0 - `V_FP - `V_SYNC - `V_BP;  // -45
    localparam fb_pkg::coord_t VS_STA = V_STA + `V_FP;
    localparam fb_pkg::coord_t VS_END = VS_STA + `V_SYNC;
    localparam fb_pkg::coord_t VA_END = `V_RES - 1;

    fb_pkg::coord_t x;  // free running position, one cycle ahead of sx
    fb_pkg::coord_t y;

    // position counters
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            x <= H_STA;
            y <= V_STA;
        end else if (x == HA_END) begin  // end of line
            x <= H_STA;
            if (y == VA_END) begin
                y <= V_STA;
            end else begin
                y <= y + fb_pkg::coord_t'(1);
            end
        end else begin
            x <= x + fb_pkg::coord_t'(1);
        end
    end

    // registered outputs, all aligned with sx and sy
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            disp.sx    <= H_STA;
            disp.sy    <= V_STA;
            disp.de    <= 1'b0;
            disp.frame <= 1'b0;
            disp.hsync <= 1'b1;
            disp.vsync <= 1'b1;
        end else begin
            disp.sx    <= x;
            disp.sy    <= y;
            disp.de    <= (x >= 0 && y >= 0);
            disp.frame <= (x == H_STA && y == V_STA);
            disp.hsync <= ~(x >= HS_STA && x < HS_END);  // negative polarity
            disp.vsync <= ~(y >= VS_STA && y < VS_END);
        end
    end

endmodule

// File: hw/display_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen position and sync bundle from the timing generator to its users.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface display_if;

    fb_pkg::coord_t sx;     // horizontal position
    fb_pkg::coord_t sy;     // vertical position
    logic de;               // data enable, low in blanking
    logic frame;            // one cycle at start of frame
    logic hsync;            // active low
    logic vsync;            // active low

    // timing generator side
    modport src (
        output sx, sy, de, frame, hsync, vsync
    );

    // consumers of the timing
    modport snk (
        input sx, sy, de, frame, hsync, vsync
    );

endinterface

// File: hw/fb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the mono framebuffer design, referenced by scoped name.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fb_defs.svh"

package fb_pkg;

    typedef logic signed [`CORDW-1:0] coord_t;   // screen position, negative in blanking
    typedef logic [$clog2(`FB_PIXELS)-1:0] fb_addr_t;
    typedef logic [0:0] fb_colr_t;               // one bit per pixel
    typedef logic [7:0] chan_t;                  // SDL colour channel

    // border drawing sequence
    typedef enum logic [2:0] {
        IDLE,
        ARMED,    // waiting for frame start
        TOP,
        RIGHT,
        LEFT,
        BOTTOM
    } draw_state_e;

endpackage

// File: include/fb_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display timing and framebuffer geometry for the mono drawing subsystem.
// Include wherever these sizes are needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// signed screen coordinate width (bits)
`define CORDW 16

// 640x480 active area
`define H_RES 640
`define V_RES 480

// horizontal blanking, in pixels
`define H_FP   16
`define H_SYNC 96
`define H_BP   48

// vertical blanking, in lines
`define V_FP   10
`define V_SYNC 2
`define V_BP   33

// framebuffer is a quarter of the screen in each direction
`define FB_WIDTH  160
`define FB_HEIGHT 120
`define FB_PIXELS 19200

`endif
